// ==== pcore_pkg.sv ====
`default_nettype none

package pcore_pkg;

    localparam int XLEN = 32;

    // Major opcodes of the supported subset
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LUI    = 7'b0110111,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_BRANCH = 7'b1100011,
        OPC_JAL    = 7'b1101111
    } type_opcode_e;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_PASS_B
    } type_alu_op_e;

    typedef enum logic [1:0] {
        FWD_NONE,
        FWD_FROM_LSU,
        FWD_FROM_WRB
    } type_fwd_sel_e;

    typedef struct packed {
        logic [XLEN-1:0] addr;
        logic            req;
    } type_if2imem_s;

    typedef struct packed {
        logic            valid;
        logic [XLEN-1:0] pc;
        logic [31:0]     instr;
    } type_if2id_s;

    typedef struct packed {
        logic            valid;
        logic [XLEN-1:0] pc;
        logic [4:0]      rs1;
        logic [4:0]      rs2;
        logic [XLEN-1:0] rs1_data;
        logic [XLEN-1:0] rs2_data;
        logic [XLEN-1:0] imm;
        logic [4:0]      rd;
        type_alu_op_e    alu_op;
        logic            alu_src_imm;
        logic            is_load;
        logic            is_store;
        logic            is_branch;
        logic            branch_ne;
        logic            is_jal;
        logic            reg_write;
    } type_id2exe_s;

    typedef struct packed {
        logic            valid;
        logic [XLEN-1:0] alu_result;
        logic [XLEN-1:0] store_data;
        logic [4:0]      rd;
        logic            is_load;
        logic            is_store;
        logic            reg_write;
    } type_exe2lsu_s;

    typedef struct packed {
        logic            valid;
        logic [4:0]      rd;
        logic [XLEN-1:0] rd_data;
        logic            reg_write;
    } type_lsu2wrb_s;

    typedef struct packed {
        logic [XLEN-1:0] addr;
        logic [XLEN-1:0] wdata;
        logic            req;
        logic            we;
    } type_lsu2dbus_s;

    typedef struct packed {
        logic [XLEN-1:0] rdata;
    } type_dbus2lsu_s;

    typedef struct packed {
        logic            redirect;
        logic [XLEN-1:0] target;
    } type_exe2if_fb_s;

    // Register file write port, also the WB forwarding source
    typedef struct packed {
        logic            we;
        logic [4:0]      rd;
        logic [XLEN-1:0] rd_data;
    } type_wrb2id_fb_s;

    typedef struct packed {
        logic          stall_if;
        logic          stall_id;
        logic          flush_if2id;
        logic          flush_id2exe;
        type_fwd_sel_e fwd_rs1;
        type_fwd_sel_e fwd_rs2;
    } type_hazard_s;

endpackage

`default_nettype wire

// ==== pipe_reg.sv ====
`timescale 1ns/1ps
`default_nettype none

module pipe_reg #(
    parameter type T = logic
) (
    input  logic clk,
    input  logic rst_n,
    input  logic stall_i,
    input  logic flush_i,
    input  T     d_i,
    output T     q_o
);

    // Flush beats stall, bubble is all zero
    always_ff @(posedge clk) begin
        if (!rst_n || flush_i) begin
            q_o <= '0;
        end else if (!stall_i) begin
            q_o <= d_i;
        end
    end

endmodule

`default_nettype wire

// ==== fetch.sv ====
`timescale 1ns/1ps
`default_nettype none

module fetch import pcore_pkg::*; #(
    parameter logic [XLEN-1:0] RESET_PC = '0
) (
    input  logic            clk,
    input  logic            rst_n,
    output type_if2imem_s   if2imem_o,
    input  logic [XLEN-1:0] imem2if_i,
    input  type_exe2if_fb_s exe2if_fb_i,
    input  type_hazard_s    hazard_i,
    output type_if2id_s     if2id_o
);

    logic [XLEN-1:0] pc;

    // Redirect from EX takes precedence over a load-use hold
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc <= RESET_PC;
        end else if (exe2if_fb_i.redirect) begin
            pc <= exe2if_fb_i.target;
        end else if (!hazard_i.stall_if) begin
            pc <= pc + XLEN'(4);
        end
    end

    assign if2imem_o.addr = pc;
    assign if2imem_o.req  = 1'b1;

    // Memory answers in the same cycle
    assign if2id_o.valid = 1'b1;
    assign if2id_o.pc    = pc;
    assign if2id_o.instr = imem2if_i;

endmodule

`default_nettype wire

// ==== decode.sv ====
`timescale 1ns/1ps
`default_nettype none

module decode import pcore_pkg::*; (
    input  logic            clk,
    input  logic            rst_n,
    input  type_if2id_s     if2id_i,
    input  type_wrb2id_fb_s wrb2id_fb_i,
    output type_id2exe_s    id2exe_o
);

    logic [XLEN-1:0] regs [32];
    logic [31:0]     instr;
    logic [6:0]      opcode;
    logic [2:0]      funct3;
    logic [6:0]      funct7;
    logic [XLEN-1:0] imm_i;
    logic [XLEN-1:0] imm_s;
    logic [XLEN-1:0] imm_b;
    logic [XLEN-1:0] imm_u;
    logic [XLEN-1:0] imm_j;
    logic            legal;
    type_id2exe_s    dec;

    assign instr  = if2id_i.instr;
    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];

    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_u = {instr[31:12], 12'b0};
    assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

    // Register file, x0 is never written
    always_ff @(posedge clk) begin
        if (rst_n && wrb2id_fb_i.we && (wrb2id_fb_i.rd != 5'd0)) begin
            regs[wrb2id_fb_i.rd] <= wrb2id_fb_i.rd_data;
        end
    end

    // Read with write-through from writeback
    function automatic logic [XLEN-1:0] rf_read(input logic [4:0] idx);
        logic [XLEN-1:0] val;
        if (idx == 5'd0) begin
            val = '0;
        end else if (wrb2id_fb_i.we && (wrb2id_fb_i.rd == idx)) begin
            val = wrb2id_fb_i.rd_data;
        end else begin
            val = regs[idx];
        end
        return val;
    endfunction

    always_comb begin
        dec        = '0;
        legal      = 1'b0;
        dec.valid  = if2id_i.valid;
        dec.pc     = if2id_i.pc;
        dec.rd     = instr[11:7];
        dec.rs1    = instr[19:15];
        dec.rs2    = instr[24:20];
        dec.alu_op = ALU_ADD;
        case (opcode)
            OPC_OP: begin
                dec.reg_write = 1'b1;
                legal = (funct7 == 7'h00) || ((funct7 == 7'h20) && (funct3 == 3'b000));
                case (funct3)
                    3'b000:  dec.alu_op = funct7[5] ? ALU_SUB : ALU_ADD;
                    3'b010:  dec.alu_op = ALU_SLT;
                    3'b100:  dec.alu_op = ALU_XOR;
                    3'b110:  dec.alu_op = ALU_OR;
                    3'b111:  dec.alu_op = ALU_AND;
                    default: legal = 1'b0;
                endcase
            end
            // ADDI only
            OPC_OP_IMM: begin
                legal           = (funct3 == 3'b000);
                dec.rs2         = '0;
                dec.imm         = imm_i;
                dec.alu_src_imm = 1'b1;
                dec.reg_write   = 1'b1;
            end
            OPC_LUI: begin
                legal           = 1'b1;
                dec.rs1         = '0;
                dec.rs2         = '0;
                dec.imm         = imm_u;
                dec.alu_op      = ALU_PASS_B;
                dec.alu_src_imm = 1'b1;
                dec.reg_write   = 1'b1;
            end
            OPC_LOAD: begin
                legal           = (funct3 == 3'b010);
                dec.rs2         = '0;
                dec.imm         = imm_i;
                dec.alu_src_imm = 1'b1;
                dec.is_load     = 1'b1;
                dec.reg_write   = 1'b1;
            end
            OPC_STORE: begin
                legal           = (funct3 == 3'b010);
                dec.rd          = '0;
                dec.imm         = imm_s;
                dec.alu_src_imm = 1'b1;
                dec.is_store    = 1'b1;
            end
            OPC_BRANCH: begin
                legal         = (funct3 == 3'b000) || (funct3 == 3'b001);
                dec.rd        = '0;
                dec.imm       = imm_b;
                dec.is_branch = 1'b1;
                dec.branch_ne = funct3[0];
            end
            OPC_JAL: begin
                legal         = 1'b1;
                dec.rs1       = '0;
                dec.rs2       = '0;
                dec.imm       = imm_j;
                dec.is_jal    = 1'b1;
                dec.reg_write = 1'b1;
            end
            default: legal = 1'b0;
        endcase
    end

    always_comb begin
        id2exe_o          = dec;
        id2exe_o.rs1_data = rf_read(dec.rs1);
        id2exe_o.rs2_data = rf_read(dec.rs2);
        // Unsupported encodings leave as a bubble
        if (!legal || !if2id_i.valid) begin
            id2exe_o = '0;
        end
    end

endmodule

`default_nettype wire

// ==== execute.sv ====
`timescale 1ns/1ps
`default_nettype none

module execute import pcore_pkg::*; (
    input  type_id2exe_s    id2exe_i,
    input  type_hazard_s    hazard_i,
    input  logic [XLEN-1:0] lsu_fwd_i,
    input  logic [XLEN-1:0] wrb_fwd_i,
    output type_exe2lsu_s   exe2lsu_o,
    output type_exe2if_fb_s exe2if_fb_o
);

    logic [XLEN-1:0] rs1_val;
    logic [XLEN-1:0] rs2_val;
    logic [XLEN-1:0] op_b;
    logic [XLEN-1:0] alu_out;
    logic [XLEN-1:0] link_pc;
    logic            branch_taken;

    function automatic logic [XLEN-1:0] fwd_mux(
        input type_fwd_sel_e   sel,
        input logic [XLEN-1:0] reg_val,
        input logic [XLEN-1:0] lsu_val,
        input logic [XLEN-1:0] wrb_val
    );
        logic [XLEN-1:0] val;
        case (sel)
            FWD_FROM_LSU: val = lsu_val;
            FWD_FROM_WRB: val = wrb_val;
            default:      val = reg_val;
        endcase
        return val;
    endfunction

    assign rs1_val = fwd_mux(hazard_i.fwd_rs1, id2exe_i.rs1_data, lsu_fwd_i, wrb_fwd_i);
    assign rs2_val = fwd_mux(hazard_i.fwd_rs2, id2exe_i.rs2_data, lsu_fwd_i, wrb_fwd_i);
    assign op_b    = id2exe_i.alu_src_imm ? id2exe_i.imm : rs2_val;

    always_comb begin
        case (id2exe_i.alu_op)
            ALU_ADD:    alu_out = rs1_val + op_b;
            ALU_SUB:    alu_out = rs1_val - op_b;
            ALU_AND:    alu_out = rs1_val & op_b;
            ALU_OR:     alu_out = rs1_val | op_b;
            ALU_XOR:    alu_out = rs1_val ^ op_b;
            ALU_SLT:    alu_out = {{(XLEN-1){1'b0}}, $signed(rs1_val) < $signed(op_b)};
            ALU_PASS_B: alu_out = op_b;
            default:    alu_out = '0;
        endcase
    end

    // BEQ and BNE share one comparator
    assign branch_taken = id2exe_i.is_branch & ((rs1_val == rs2_val) ^ id2exe_i.branch_ne);
    assign link_pc      = id2exe_i.pc + XLEN'(4);

    assign exe2if_fb_o.redirect = id2exe_i.valid & (branch_taken | id2exe_i.is_jal);
    assign exe2if_fb_o.target   = id2exe_i.pc + id2exe_i.imm;

    assign exe2lsu_o.valid      = id2exe_i.valid;
    assign exe2lsu_o.alu_result = id2exe_i.is_jal ? link_pc : alu_out;
    assign exe2lsu_o.store_data = rs2_val;
    assign exe2lsu_o.rd         = id2exe_i.rd;
    assign exe2lsu_o.is_load    = id2exe_i.is_load;
    assign exe2lsu_o.is_store   = id2exe_i.is_store;
    assign exe2lsu_o.reg_write  = id2exe_i.reg_write;

endmodule

`default_nettype wire

// ==== lsu.sv ====
`timescale 1ns/1ps
`default_nettype none

module lsu import pcore_pkg::*; (
    input  type_exe2lsu_s  exe2lsu_i,
    output type_lsu2dbus_s lsu2dbus_o,
    input  type_dbus2lsu_s dbus2lsu_i,
    output type_lsu2wrb_s  lsu2wrb_o
);

    logic mem_access;

    assign mem_access = exe2lsu_i.valid & (exe2lsu_i.is_load | exe2lsu_i.is_store);

    // Word accesses only, address straight from the ALU
    assign lsu2dbus_o.addr  = exe2lsu_i.alu_result;
    assign lsu2dbus_o.wdata = exe2lsu_i.store_data;
    assign lsu2dbus_o.req   = mem_access;
    assign lsu2dbus_o.we    = exe2lsu_i.valid & exe2lsu_i.is_store;

    assign lsu2wrb_o.valid     = exe2lsu_i.valid;
    assign lsu2wrb_o.rd        = exe2lsu_i.rd;
    assign lsu2wrb_o.reg_write = exe2lsu_i.valid & exe2lsu_i.reg_write;

    // Load data arrives in the same cycle
    assign lsu2wrb_o.rd_data = exe2lsu_i.is_load ? dbus2lsu_i.rdata : exe2lsu_i.alu_result;

endmodule

`default_nettype wire

// ==== hazard_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module hazard_unit import pcore_pkg::*; (
    input  logic [4:0]      id_rs1_i,
    input  logic [4:0]      id_rs2_i,
    input  type_id2exe_s    id2exe_i,
    input  type_exe2lsu_s   exe2lsu_i,
    input  type_lsu2wrb_s   lsu2wrb_i,
    input  type_exe2if_fb_s exe2if_fb_i,
    output type_hazard_s    hazard_o
);

    logic load_use;

    // LSU stage is younger so it wins over WB
    function automatic type_fwd_sel_e fwd_select(
        input logic [4:0]    rs,
        input type_exe2lsu_s lsu_stage,
        input type_lsu2wrb_s wrb_stage
    );
        type_fwd_sel_e sel;
        sel = FWD_NONE;
        if (rs != 5'd0) begin
            if (lsu_stage.valid && lsu_stage.reg_write && (lsu_stage.rd == rs)) begin
                sel = FWD_FROM_LSU;
            end else if (wrb_stage.valid && wrb_stage.reg_write && (wrb_stage.rd == rs)) begin
                sel = FWD_FROM_WRB;
            end
        end
        return sel;
    endfunction

    // Load in EX whose result the ID instruction needs
    assign load_use = id2exe_i.valid & id2exe_i.is_load & (id2exe_i.rd != 5'd0) &
                      ((id2exe_i.rd == id_rs1_i) | (id2exe_i.rd == id_rs2_i));

    assign hazard_o.stall_if     = load_use;
    assign hazard_o.stall_id     = load_use;
    assign hazard_o.flush_if2id  = exe2if_fb_i.redirect;
    assign hazard_o.flush_id2exe = exe2if_fb_i.redirect | load_use;
    assign hazard_o.fwd_rs1      = fwd_select(id2exe_i.rs1, exe2lsu_i, lsu2wrb_i);
    assign hazard_o.fwd_rs2      = fwd_select(id2exe_i.rs2, exe2lsu_i, lsu2wrb_i);

endmodule

`default_nettype wire

// ==== pipeline_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module pipeline_top import pcore_pkg::*; #(
    parameter logic [XLEN-1:0] RESET_PC = '0
) (
    input  logic            clk,
    input  logic            rst_n,
    output type_if2imem_s   if2imem_o,
    input  logic [XLEN-1:0] imem2if_i,
    output type_lsu2dbus_s  lsu2dbus_o,
    input  type_dbus2lsu_s  dbus2lsu_i
);

    type_if2id_s     if2id_d;
    type_if2id_s     if2id_q;
    type_id2exe_s    id2exe_d;
    type_id2exe_s    id2exe_q;
    type_exe2lsu_s   exe2lsu_d;
    type_exe2lsu_s   exe2lsu_q;
    type_lsu2wrb_s   lsu2wrb_d;
    type_lsu2wrb_s   lsu2wrb_q;
    type_exe2if_fb_s exe2if_fb;
    type_wrb2id_fb_s wrb2id_fb;
    type_hazard_s    hazard;

    fetch #(
        .RESET_PC (RESET_PC)
    ) fetch_module (
        .clk         (clk),
        .rst_n       (rst_n),
        .if2imem_o   (if2imem_o),
        .imem2if_i   (imem2if_i),
        .exe2if_fb_i (exe2if_fb),
        .hazard_i    (hazard),
        .if2id_o     (if2id_d)
    );

    pipe_reg #(.T(type_if2id_s)) if2id_reg (
        .clk     (clk),
        .rst_n   (rst_n),
        .stall_i (hazard.stall_id),
        .flush_i (hazard.flush_if2id),
        .d_i     (if2id_d),
        .q_o     (if2id_q)
    );

    decode decode_module (
        .clk         (clk),
        .rst_n       (rst_n),
        .if2id_i     (if2id_q),
        .wrb2id_fb_i (wrb2id_fb),
        .id2exe_o    (id2exe_d)
    );

    pipe_reg #(.T(type_id2exe_s)) id2exe_reg (
        .clk     (clk),
        .rst_n   (rst_n),
        .stall_i (1'b0),
        .flush_i (hazard.flush_id2exe),
        .d_i     (id2exe_d),
        .q_o     (id2exe_q)
    );

    execute execute_module (
        .id2exe_i    (id2exe_q),
        .hazard_i    (hazard),
        .lsu_fwd_i   (exe2lsu_q.alu_result),
        .wrb_fwd_i   (lsu2wrb_q.rd_data),
        .exe2lsu_o   (exe2lsu_d),
        .exe2if_fb_o (exe2if_fb)
    );

    pipe_reg #(.T(type_exe2lsu_s)) exe2lsu_reg (
        .clk     (clk),
        .rst_n   (rst_n),
        .stall_i (1'b0),
        .flush_i (1'b0),
        .d_i     (exe2lsu_d),
        .q_o     (exe2lsu_q)
    );

    lsu lsu_module (
        .exe2lsu_i  (exe2lsu_q),
        .lsu2dbus_o (lsu2dbus_o),
        .dbus2lsu_i (dbus2lsu_i),
        .lsu2wrb_o  (lsu2wrb_d)
    );

    // Writeback register is never stalled or flushed
    pipe_reg #(.T(type_lsu2wrb_s)) lsu2wrb_reg (
        .clk     (clk),
        .rst_n   (rst_n),
        .stall_i (1'b0),
        .flush_i (1'b0),
        .d_i     (lsu2wrb_d),
        .q_o     (lsu2wrb_q)
    );

    assign wrb2id_fb.we      = lsu2wrb_q.reg_write;
    assign wrb2id_fb.rd      = lsu2wrb_q.rd;
    assign wrb2id_fb.rd_data = lsu2wrb_q.rd_data;

    hazard_unit hazard_module (
        .id_rs1_i    (id2exe_d.rs1),
        .id_rs2_i    (id2exe_d.rs2),
        .id2exe_i    (id2exe_q),
        .exe2lsu_i   (exe2lsu_q),
        .lsu2wrb_i   (lsu2wrb_q),
        .exe2if_fb_i (exe2if_fb),
        .hazard_o    (hazard)
    );

endmodule

`default_nettype wire

// ==== pipeline_asserts.sv ====
`timescale 1ns/1ps
`default_nettype none

module pipeline_asserts import pcore_pkg::*; (
    input logic            clk,
    input logic            rst_n,
    input type_if2imem_s   if2imem_i,
    input type_lsu2dbus_s  lsu2dbus_i,
    input type_hazard_s    hazard_i,
    input type_exe2if_fb_s exe2if_fb_i,
    input type_if2id_s     if2id_i,
    input type_id2exe_s    id2exe_i
);

    // A reset edge clears the LSU stage before the next edge
    no_dbus_req_in_reset: assert property (@(posedge clk) !rst_n |=> !lsu2dbus_i.req)
        else $error("data bus request while the core is in reset");

    pc_word_aligned: assert property (@(posedge clk) disable iff (!rst_n)
        if2imem_i.addr[1:0] == 2'b00)
        else $error("fetch address %h is not word aligned", if2imem_i.addr);

    // Load-use hold keeps the PC and if2id, and puts a bubble into id2exe
    load_use_hold: assert property (@(posedge clk) disable iff (!rst_n)
        (hazard_i.stall_if && !exe2if_fb_i.redirect)
        |=> ($stable(if2imem_i.addr) && $stable(if2id_i) && !id2exe_i.valid))
        else $error("load-use stall did not hold fetch or did not insert a bubble");

endmodule

bind pipeline_top pipeline_asserts pipeline_asserts_inst (
    .clk         (clk),
    .rst_n       (rst_n),
    .if2imem_i   (if2imem_o),
    .lsu2dbus_i  (lsu2dbus_o),
    .hazard_i    (hazard),
    .exe2if_fb_i (exe2if_fb),
    .if2id_i     (if2id_q),
    .id2exe_i    (id2exe_q)
);

`default_nettype wire

// ==== tb_pipeline_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_pipeline_top import pcore_pkg::*;;

    localparam int CLK_PERIOD = 100;
    localparam logic [31:0] HALT = 32'h0000006f;

    // R-type selectors for rtype()
    localparam int R_ADD = 0;
    localparam int R_SUB = 1;
    localparam int R_AND = 2;
    localparam int R_OR  = 3;
    localparam int R_XOR = 4;
    localparam int R_SLT = 5;

    logic           clk;
    logic           rst_n;
    type_if2imem_s  if2imem;
    logic [31:0]    imem_rdata;
    type_lsu2dbus_s dbus_req;
    type_dbus2lsu_s dbus_rsp;

    logic [31:0] imem [256];
    logic [31:0] dmem [256];
    logic [31:0] exp_addr [$];
    logic [31:0] exp_data [$];
    logic [31:0] lfsr_state;
    int          prog_len;
    int          seen;
    int          test_errors;
    int          tests_passed;
    int          tests_failed;
    logic        active;
    time         deadline;

    pipeline_top #(
        .RESET_PC ('0)
    ) uut (
        .clk        (clk),
        .rst_n      (rst_n),
        .if2imem_o  (if2imem),
        .imem2if_i  (imem_rdata),
        .lsu2dbus_o (dbus_req),
        .dbus2lsu_i (dbus_rsp)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // Both memories read combinationally and only on request
    assign imem_rdata     = if2imem.req ? imem[if2imem.addr[9:2]] : '0;
    assign dbus_rsp.rdata = dbus_req.req ? dmem[dbus_req.addr[9:2]] : '0;

    always @(posedge clk) begin
        if (dbus_req.req && dbus_req.we) begin
            dmem[dbus_req.addr[9:2]] <= dbus_req.wdata;
        end
    end

    function automatic logic [31:0] fill_word(input int idx);
        return {8'hc3 ^ idx[7:0], ~idx[7:0], idx[7:0] + 8'h11, idx[7:0]};
    endfunction

    // Galois LFSR, x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        logic [31:0] n;
        n = s >> 1;
        if (s[0]) begin
            n = n ^ 32'h80200003;
        end
        return n;
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr_state[0]};
            lfsr_state = lfsr_step(lfsr_state);
        end
        return v;
    endfunction

    function automatic logic [31:0] rtype(input int op, input int rd, input int rs1,
                                          input int rs2);
        logic [2:0] f3;
        logic [6:0] f7;
        f7 = 7'h00;
        case (op)
            R_ADD: f3 = 3'b000;
            R_SUB: begin
                f3 = 3'b000;
                f7 = 7'h20;
            end
            R_AND: f3 = 3'b111;
            R_OR:  f3 = 3'b110;
            R_XOR: f3 = 3'b100;
            default: f3 = 3'b010;
        endcase
        return {f7, rs2[4:0], rs1[4:0], f3, rd[4:0], 7'h33};
    endfunction

    function automatic logic [31:0] addi(input int rd, input int rs1, input int imm);
        return {imm[11:0], rs1[4:0], 3'b000, rd[4:0], 7'h13};
    endfunction

    function automatic logic [31:0] lw(input int rd, input int rs1, input int imm);
        return {imm[11:0], rs1[4:0], 3'b010, rd[4:0], 7'h03};
    endfunction

    function automatic logic [31:0] sw(input int rs2, input int rs1, input int imm);
        return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], 7'h23};
    endfunction

    function automatic logic [31:0] lui(input int rd, input int imm);
        return {imm[19:0], rd[4:0], 7'h37};
    endfunction

    function automatic logic [31:0] branch(input int ne, input int rs1, input int rs2,
                                           input int off);
        return {off[12], off[10:5], rs2[4:0], rs1[4:0], 2'b00, ne[0], off[4:1], off[11],
                7'h63};
    endfunction

    function automatic logic [31:0] jal(input int rd, input int off);
        return {off[20], off[10:1], off[11], off[19:12], rd[4:0], 7'h6f};
    endfunction

    // Architectural model, collects the stores in program order
    function automatic int iss_run();
        logic [31:0] regs [32];
        logic [31:0] mem [256];
        logic [31:0] pc;
        logic [31:0] next_pc;
        logic [31:0] ins;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] addr;
        logic [31:0] imm_i;
        logic [31:0] imm_s;
        logic [31:0] imm_b;
        logic [31:0] imm_j;
        int          steps;
        exp_addr.delete();
        exp_data.delete();
        for (int i = 0; i < 32; i++) begin
            regs[i] = '0;
        end
        for (int i = 0; i < 256; i++) begin
            mem[i] = fill_word(i);
        end
        pc = '0;
        steps = 0;
        while (steps < 4000) begin
            ins = imem[pc[9:2]];
            if (ins == HALT) begin
                break;
            end
            a       = regs[ins[19:15]];
            b       = regs[ins[24:20]];
            imm_i   = {{20{ins[31]}}, ins[31:20]};
            imm_s   = {{20{ins[31]}}, ins[31:25], ins[11:7]};
            imm_b   = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
            imm_j   = {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
            next_pc = pc + 32'd4;
            case (ins[6:0])
                7'h33: begin
                    case (ins[14:12])
                        3'b000: regs[ins[11:7]] = ins[30] ? a - b : a + b;
                        3'b010: regs[ins[11:7]] = {31'd0, $signed(a) < $signed(b)};
                        3'b100: regs[ins[11:7]] = a ^ b;
                        3'b110: regs[ins[11:7]] = a | b;
                        default: regs[ins[11:7]] = a & b;
                    endcase
                end
                7'h13: regs[ins[11:7]] = a + imm_i;
                7'h37: regs[ins[11:7]] = {ins[31:12], 12'h000};
                7'h03: begin
                    addr = a + imm_i;
                    regs[ins[11:7]] = mem[addr[9:2]];
                end
                7'h23: begin
                    addr = a + imm_s;
                    mem[addr[9:2]] = b;
                    exp_addr.push_back(addr);
                    exp_data.push_back(b);
                end
                7'h63: begin
                    if ((a == b) != ins[12]) begin
                        next_pc = pc + imm_b;
                    end
                end
                7'h6f: begin
                    regs[ins[11:7]] = pc + 32'd4;
                    next_pc = pc + imm_j;
                end
                default: ;
            endcase
            regs[0] = '0;
            pc = next_pc;
            steps++;
        end
        return exp_addr.size();
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("mismatch %s: got %h, expected %h at %0t", name, got, exp, $time);
            test_errors++;
        end
    endtask

    // Every store the core issues is compared in order
    always @(posedge clk) begin
        if (active && rst_n && dbus_req.req && dbus_req.we) begin
            if (seen >= exp_addr.size()) begin
                $display("Unexpected extra store of %h to address %h at %0t",
                         dbus_req.wdata, dbus_req.addr, $time);
                test_errors++;
            end else begin
                check_value("lsu2dbus_o.addr", dbus_req.addr, exp_addr[seen]);
                check_value("lsu2dbus_o.wdata", dbus_req.wdata, exp_data[seen]);
            end
            seen++;
        end
    end

    always @(posedge clk) begin
        if ($time > deadline) begin
            $display("Watchdog expired at %0t, the core stopped making progress", $time);
            $display("Simulation failed");
            $finish;
        end
    end

    task automatic emit(input logic [31:0] word);
        imem[prog_len] = word;
        prog_len++;
    endtask

    // Core goes into reset before its program is replaced
    task automatic begin_test();
        @(negedge clk);
        rst_n = 1'b0;
        for (int i = 0; i < 256; i++) begin
            imem[i] = '0;
        end
        prog_len = 0;
    endtask

    task automatic run_test(input string name);
        int n;
        int budget;
        int cyc;
        budget   = 10 * prog_len + 50;
        deadline = $time + (budget + 40) * CLK_PERIOD;
        @(negedge clk);
        for (int i = 0; i < 256; i++) begin
            dmem[i] = fill_word(i);
        end
        n = iss_run();
        seen = 0;
        test_errors = 0;
        repeat (2) @(negedge clk);
        rst_n  = 1'b1;
        active = 1'b1;
        cyc = 0;
        while (seen < n && cyc < budget) begin
            @(negedge clk);
            cyc++;
        end
        if (seen < n) begin
            $display("%s: missing store, only %0d of %0d stores seen", name, seen, n);
            test_errors++;
        end else begin
            // Quiet window to catch stores past the end
            repeat (10) @(negedge clk);
        end
        active = 1'b0;
        if (test_errors == 0) begin
            tests_passed++;
        end else begin
            tests_failed++;
        end
        $display("%-16s %s, %0d stores, %0d errors", name,
                 (test_errors == 0) ? "ok" : "FAILED", n, test_errors);
    endtask

    task automatic build_random();
        int kind;
        int rd;
        int rs1;
        int rs2;
        for (int r = 1; r < 8; r++) begin
            emit(addi(r, 0, rand_bits(12)));
        end
        for (int k = 0; k < 24; k++) begin
            kind = rand_bits(3);
            rd   = rand_bits(3);
            rs1  = rand_bits(3);
            rs2  = rand_bits(3);
            if (kind < 6) begin
                emit(rtype(kind, rd, rs1, rs2));
            end else if (kind == 6) begin
                emit(addi(rd, rs1, rand_bits(12)));
            end else begin
                emit(lui(rd, rand_bits(20)));
            end
        end
        for (int r = 1; r < 8; r++) begin
            emit(sw(r, 0, 'h200 + 4 * r));
        end
        emit(HALT);
    endtask

    initial begin
        clk          = 1'b0;
        rst_n        = 1'b0;
        active       = 1'b0;
        seen         = 0;
        prog_len     = 0;
        test_errors  = 0;
        tests_passed = 0;
        tests_failed = 0;
        lfsr_state   = 32'd74;
        deadline     = 100 * CLK_PERIOD;
        for (int i = 0; i < 256; i++) begin
            imem[i] = '0;
            dmem[i] = fill_word(i);
        end

        // Dependent ALU chain, distances 1 to 3
        begin_test();
        emit(lui(1, 'h12345));
        emit(addi(2, 1, 'h678));
        emit(rtype(R_ADD, 3, 2, 1));
        emit(rtype(R_SUB, 4, 3, 2));
        emit(sw(4, 0, 'h100));
        emit(rtype(R_XOR, 5, 4, 3));
        emit(rtype(R_OR, 6, 5, 1));
        emit(rtype(R_AND, 7, 6, 5));
        emit(rtype(R_SLT, 8, 7, 6));
        emit(addi(9, 8, -5));
        emit(rtype(R_SLT, 10, 9, 0));
        emit(sw(10, 0, 'h104));
        emit(sw(2, 0, 'h108));
        emit(sw(3, 0, 'h10c));
        emit(sw(5, 0, 'h110));
        emit(sw(6, 0, 'h114));
        emit(sw(7, 0, 'h118));
        emit(sw(9, 0, 'h11c));
        emit(HALT);
        run_test("alu_chain");

        // Loads consumed by the very next instruction
        begin_test();
        emit(addi(1, 0, 'h40));
        emit(lw(2, 1, 0));
        emit(rtype(R_ADD, 3, 2, 2));
        emit(sw(3, 0, 'h180));
        emit(lw(4, 1, 4));
        emit(sw(4, 0, 'h184));
        emit(lw(5, 1, 8));
        emit(addi(6, 5, 1));
        emit(sw(6, 0, 'h188));
        emit(lw(7, 0, 'h180));
        emit(sw(7, 0, 'h18c));
        emit(HALT);
        run_test("load_use");

        // Byte offsets of each word are noted where a branch lands
        begin_test();
        emit(addi(1, 0, 5));
        emit(addi(2, 0, 5));
        emit(addi(3, 0, 7));
        emit(branch(0, 1, 2, 12));
        emit(sw(1, 0, 'h1f0));
        emit(sw(2, 0, 'h1f4));
        emit(branch(1, 1, 3, 12));   // 24
        emit(sw(3, 0, 'h1f8));
        emit(sw(3, 0, 'h1fc));
        emit(branch(0, 1, 3, 8));    // 36, not taken
        emit(sw(1, 0, 'h140));
        emit(branch(1, 1, 2, 8));    // 44, not taken
        emit(sw(2, 0, 'h144));
        emit(jal(5, 12));            // 52, links 56
        emit(sw(1, 0, 'h1e0));
        emit(sw(2, 0, 'h1e4));
        emit(sw(5, 0, 'h148));       // 64
        emit(addi(6, 0, 3));
        emit(addi(6, 6, -1));        // 72
        emit(branch(1, 6, 0, -4));
        emit(sw(6, 0, 'h14c));
        emit(HALT);
        run_test("branch_jal");

        begin_test();
        emit(addi(0, 0, 'h123));
        emit(lui(0, 'habcde));
        emit(addi(1, 0, 'h55));
        emit(rtype(R_ADD, 0, 1, 1));
        emit(sw(0, 0, 'h160));
        emit(lw(0, 0, 'h40));
        emit(sw(0, 0, 'h164));
        emit(rtype(R_ADD, 2, 0, 1));
        emit(sw(2, 0, 'h168));
        emit(HALT);
        run_test("x0_writes");

        for (int t = 0; t < 3; t++) begin
            begin_test();
            build_random();
            run_test($sformatf("random_%0d", t));
        end

        $display("%0d tests run, %0d passed, %0d failed",
                 tests_passed + tests_failed, tests_passed, tests_failed);
        if (tests_failed == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== vlog.f ====
pcore_pkg.sv
pipe_reg.sv
fetch.sv
decode.sv
execute.sv
lsu.sv
hazard_unit.sv
pipeline_top.sv
pipeline_asserts.sv
tb_pipeline_top.sv
